// ==== Makefile ====
# Verilator build and run for the RV32I pipeline core

VERILATOR ?= verilator
TOP       ?= tbRvCore
RTL_TOP   ?= rvCore
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing
PASS_MSG  ?= test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# Pass only when the pass message shows up as a line of its own
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== design/rvCore.sv ====
`timescale 1ns/1ps

module rvCore (
    input  logic                       iCLK,
    input  logic                       iRST,
    input  logic [rvCorePkg::XLEN-1:0] instr,
    output logic [rvCorePkg::XLEN-1:0] pc,
    output rvCorePkg::retireT          retire,
    output logic [rvCorePkg::XLEN-1:0] retiredCount
);
    import rvCorePkg::*;

    fetchT    fetchStage;     // Fetch to decode
    decodeT   decodeStage;    // Decode to execute
    retireT   execResult;     // Execute to result, combinational
    redirectT redirect;       // Taken branch or jump

    // ********************
    // Pipeline

    rvFetch fetch0 (
        .iCLK     (iCLK),
        .iRST     (iRST),
        .instr    (instr),
        .redirect (redirect),
        .pc       (pc),
        .fetch    (fetchStage)
    );

    rvDecode decode0 (
        .iCLK      (iCLK),
        .iRST      (iRST),
        .fetch     (fetchStage),
        .redirect  (redirect),
        .writeBack (retire),        // Register write from the result stage
        .decoded   (decodeStage)
    );

    rvExecute execute0 (
        .decoded   (decodeStage),
        .resultFwd (retire),
        .executed  (execResult),
        .redirect  (redirect)
    );

    rvResult result0 (
        .iCLK         (iCLK),
        .iRST         (iRST),
        .executed     (execResult),
        .retire       (retire),
        .retiredCount (retiredCount)
    );

endmodule

// ==== design/rvCorePkg.sv ====
package rvCorePkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [XLEN-1:0] RESET_PC  = 32'h0000_0000;
    localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013;  // addi x0, x0, 0

    // ********************
    // Encodings

    // Major opcodes handled by the core
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011
    } opcodeE;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND,
        PASSB                   // Operand B straight through
    } aluOpE;

    typedef enum logic [1:0] {
        SRCA_REG,
        SRCA_PC,
        SRCA_ZERO
    } srcAE;

    typedef enum logic [1:0] {
        SRCB_REG,
        SRCB_IMM,
        SRCB_FOUR               // Link value for jumps
    } srcBE;

    // ********************
    // Stage payloads

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       instr;
    } fetchT;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       rs1Val;
        logic [XLEN-1:0]       rs2Val;
        logic [XLEN-1:0]       imm;
        aluOpE                 aluOp;
        srcAE                  srcA;
        srcBE                  srcB;
        logic [2:0]            funct3;
        logic                  isBranch;
        logic                  isJal;
        logic                  isJalr;
        logic                  regWrite;
    } decodeT;

    typedef struct packed {
        logic                  take;
        logic [XLEN-1:0]       target;
    } redirectT;

    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
    } retireT;

endpackage

// ==== design/rvDecode.sv ====
`timescale 1ns/1ps

module rvDecode (
    input  logic                iCLK,
    input  logic                iRST,
    input  rvCorePkg::fetchT    fetch,
    input  rvCorePkg::redirectT redirect,
    input  rvCorePkg::retireT   writeBack,
    output rvCorePkg::decodeT   decoded
);
    import rvCorePkg::*;

    logic [XLEN-1:0] instrWord;
    logic [XLEN-1:0] immI;
    logic [XLEN-1:0] immU;
    logic [XLEN-1:0] immB;
    logic [XLEN-1:0] immJ;
    logic [XLEN-1:0] rs1Val;
    logic [XLEN-1:0] rs2Val;
    decodeT          decNext;

    assign instrWord = fetch.instr;

    // ********************
    // Immediates

    assign immI = {{20{instrWord[31]}}, instrWord[31:20]};
    assign immU = {instrWord[31:12], 12'b0};
    assign immB = {{19{instrWord[31]}}, instrWord[31], instrWord[7],
                   instrWord[30:25], instrWord[11:8], 1'b0};
    assign immJ = {{11{instrWord[31]}}, instrWord[31], instrWord[19:12],
                   instrWord[20], instrWord[30:21], 1'b0};

    rvRegFile regFile0 (
        .iCLK      (iCLK),
        .iRST      (iRST),
        .rs1       (instrWord[19:15]),
        .rs2       (instrWord[24:20]),
        .writeBack (writeBack),
        .rs1Val    (rs1Val),
        .rs2Val    (rs2Val)
    );

    // ALU operation from funct3, SUB only exists in register form
    function automatic aluOpE aluFunct(input logic [2:0] f3, input logic alt, input logic isReg);
        case (f3)
            3'b000:  return (alt && isReg) ? SUB : ADD;
            3'b001:  return SLL;
            3'b010:  return SLT;
            3'b011:  return SLTU;
            3'b100:  return XOR;
            3'b101:  return alt ? SRA : SRL;
            3'b110:  return OR;
            default: return AND;
        endcase
    endfunction

    always_comb begin
        decNext        = '0;
        decNext.valid  = fetch.valid;
        decNext.pc     = fetch.pc;
        decNext.rs1    = instrWord[19:15];
        decNext.rs2    = instrWord[24:20];
        decNext.rd     = instrWord[11:7];
        decNext.rs1Val = rs1Val;
        decNext.rs2Val = rs2Val;
        decNext.funct3 = instrWord[14:12];
        decNext.aluOp  = ADD;
        decNext.srcA   = SRCA_REG;
        decNext.srcB   = SRCB_REG;
        case (opcodeE'(instrWord[6:0]))
            OP: begin
                decNext.aluOp    = aluFunct(instrWord[14:12], instrWord[30], 1'b1);
                decNext.regWrite = 1'b1;
            end
            OP_IMM: begin
                decNext.aluOp    = aluFunct(instrWord[14:12], instrWord[30], 1'b0);
                decNext.srcB     = SRCB_IMM;
                decNext.imm      = immI;
                decNext.regWrite = 1'b1;
            end
            LUI: begin
                decNext.aluOp    = PASSB;
                decNext.srcA     = SRCA_ZERO;
                decNext.srcB     = SRCB_IMM;
                decNext.imm      = immU;
                decNext.regWrite = 1'b1;
            end
            AUIPC: begin
                decNext.srcA     = SRCA_PC;
                decNext.srcB     = SRCB_IMM;
                decNext.imm      = immU;
                decNext.regWrite = 1'b1;
            end
            JAL, JALR: begin
                decNext.srcA     = SRCA_PC;         // PC + 4 is the link value
                decNext.srcB     = SRCB_FOUR;
                decNext.imm      = instrWord[3] ? immJ : immI;
                decNext.isJal    = instrWord[3];
                decNext.isJalr   = ~instrWord[3];
                decNext.regWrite = 1'b1;
            end
            BRANCH: begin
                decNext.imm      = immB;
                decNext.isBranch = 1'b1;
            end
            default: decNext.valid = 1'b0;          // Not kept, becomes a bubble
        endcase
    end

    always_ff @(posedge iCLK or posedge iRST) begin
        if (iRST)
            decoded <= '0;
        else if (redirect.take)
            decoded <= '0;                          // Wrong-path instruction
        else
            decoded <= decNext;
    end

endmodule

// ==== design/rvExecute.sv ====
`timescale 1ns/1ps

module rvExecute (
    input  rvCorePkg::decodeT   decoded,
    input  rvCorePkg::retireT   resultFwd,
    output rvCorePkg::retireT   executed,
    output rvCorePkg::redirectT redirect
);
    import rvCorePkg::*;

    logic [XLEN-1:0] rs1Fwd;
    logic [XLEN-1:0] rs2Fwd;
    logic [XLEN-1:0] opA;
    logic [XLEN-1:0] opB;
    logic [XLEN-1:0] aluResult;
    logic [XLEN-1:0] jumpTarget;
    logic            taken;

    // Result stage bypass, x0 never forwarded
    function automatic logic [XLEN-1:0] forward(input logic [REG_ADDR_W-1:0] src,
                                                input logic [XLEN-1:0]       regVal,
                                                input retireT                fwd);
        if (fwd.valid && (fwd.rd == src) && (src != '0))
            return fwd.data;
        else
            return regVal;
    endfunction

    assign rs1Fwd = forward(decoded.rs1, decoded.rs1Val, resultFwd);
    assign rs2Fwd = forward(decoded.rs2, decoded.rs2Val, resultFwd);

    // ********************
    // ALU

    always_comb begin
        case (decoded.srcA)
            SRCA_PC:   opA = decoded.pc;
            SRCA_ZERO: opA = '0;
            default:   opA = rs1Fwd;
        endcase
        case (decoded.srcB)
            SRCB_IMM:  opB = decoded.imm;
            SRCB_FOUR: opB = XLEN'(4);
            default:   opB = rs2Fwd;
        endcase
    end

    always_comb begin
        case (decoded.aluOp)
            SUB:     aluResult = opA - opB;
            SLL:     aluResult = opA << opB[4:0];
            SLT:     aluResult = {{(XLEN-1){1'b0}}, $signed(opA) < $signed(opB)};
            SLTU:    aluResult = {{(XLEN-1){1'b0}}, opA < opB};
            XOR:     aluResult = opA ^ opB;
            SRL:     aluResult = opA >> opB[4:0];
            SRA:     aluResult = $unsigned($signed(opA) >>> opB[4:0]);
            OR:      aluResult = opA | opB;
            AND:     aluResult = opA & opB;
            PASSB:   aluResult = opB;
            default: aluResult = opA + opB;
        endcase
    end

    // ********************
    // Branch decision and target

    always_comb begin
        case (decoded.funct3)
            3'b000:  taken = (rs1Fwd == rs2Fwd);                    // beq
            3'b001:  taken = (rs1Fwd != rs2Fwd);                    // bne
            3'b100:  taken = ($signed(rs1Fwd) < $signed(rs2Fwd));   // blt
            3'b101:  taken = ($signed(rs1Fwd) >= $signed(rs2Fwd));  // bge
            3'b110:  taken = (rs1Fwd < rs2Fwd);                     // bltu
            3'b111:  taken = (rs1Fwd >= rs2Fwd);                    // bgeu
            default: taken = 1'b0;
        endcase
    end

    assign jumpTarget = decoded.isJalr ? ((rs1Fwd + decoded.imm) & ~XLEN'(1))
                                       : decoded.pc + decoded.imm;

    assign redirect.take   = decoded.valid &
                             (decoded.isJal | decoded.isJalr | (decoded.isBranch & taken));
    assign redirect.target = jumpTarget;

    // Item stays valid for counting, a non-writing one targets x0
    assign executed.valid = decoded.valid;
    assign executed.rd    = decoded.regWrite ? decoded.rd : '0;
    assign executed.data  = aluResult;

endmodule

// ==== design/rvFetch.sv ====
`timescale 1ns/1ps

module rvFetch (
    input  logic                       iCLK,
    input  logic                       iRST,
    input  logic [rvCorePkg::XLEN-1:0] instr,
    input  rvCorePkg::redirectT        redirect,
    output logic [rvCorePkg::XLEN-1:0] pc,
    output rvCorePkg::fetchT           fetch
);
    import rvCorePkg::*;

    logic [XLEN-1:0] pcNext;
    logic [XLEN-1:0] fetchPc;       // Address of the word arriving this cycle
    logic            issued;        // An address has gone out since reset
    logic            flushPending;  // Arriving word belongs to the abandoned path
    logic            wordValid;

    // ********************
    // Next PC

    assign pcNext = redirect.take ? redirect.target : pc + XLEN'(4);

    always_ff @(posedge iCLK or posedge iRST) begin
        if (iRST) begin
            pc           <= RESET_PC;
            fetchPc      <= '0;
            issued       <= 1'b0;
            flushPending <= 1'b0;
        end else begin
            pc           <= pcNext;
            fetchPc      <= pc;             // Memory answers one clock later
            issued       <= 1'b1;
            flushPending <= redirect.take;
        end
    end

    // ********************
    // Pair the returning word with its address

    assign wordValid = issued & ~flushPending;

    assign fetch.valid = wordValid;
    assign fetch.pc    = fetchPc;
    assign fetch.instr = wordValid ? instr : NOP_INSTR;  // Dropped words become bubbles

endmodule

// ==== design/rvRegFile.sv ====
`timescale 1ns/1ps

module rvRegFile (
    input  logic                             iCLK,
    input  logic                             iRST,
    input  logic [rvCorePkg::REG_ADDR_W-1:0] rs1,
    input  logic [rvCorePkg::REG_ADDR_W-1:0] rs2,
    input  rvCorePkg::retireT                writeBack,
    output logic [rvCorePkg::XLEN-1:0]       rs1Val,
    output logic [rvCorePkg::XLEN-1:0]       rs2Val
);
    import rvCorePkg::*;

    logic [XLEN-1:0] regs [1:31];   // x0 is not stored
    logic            writeEn;

    assign writeEn = writeBack.valid && (writeBack.rd != '0);

    always_ff @(posedge iCLK or posedge iRST) begin
        if (iRST) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn) begin
            regs[writeBack.rd] <= writeBack.data;
        end
    end

    // Write-through read, x0 reads as zero
    function automatic logic [XLEN-1:0] readPort(input logic [REG_ADDR_W-1:0] idx);
        if (idx == '0)
            return '0;
        else if (writeEn && (idx == writeBack.rd))
            return writeBack.data;
        else
            return regs[idx];
    endfunction

    always_comb begin
        rs1Val = readPort(rs1);
        rs2Val = readPort(rs2);
    end

endmodule

// ==== design/rvResult.sv ====
`timescale 1ns/1ps

module rvResult (
    input  logic                       iCLK,
    input  logic                       iRST,
    input  rvCorePkg::retireT          executed,
    output rvCorePkg::retireT          retire,
    output logic [rvCorePkg::XLEN-1:0] retiredCount
);
    import rvCorePkg::*;

    logic writesReg;

    assign writesReg = executed.valid && (executed.rd != '0);  // x0 writes vanish here

    always_ff @(posedge iCLK or posedge iRST) begin
        if (iRST) begin
            retire <= '0;
        end else begin
            retire.valid <= writesReg;
            retire.rd    <= executed.rd;
            retire.data  <= executed.data;
        end
    end

    // ********************
    // Retire counter, bubbles are not counted

    always_ff @(posedge iCLK or posedge iRST) begin
        if (iRST)
            retiredCount <= '0;
        else if (executed.valid)
            retiredCount <= retiredCount + XLEN'(1);
    end

endmodule

// ==== testbench/tbRvCore.sv ====
`timescale 1ns/1ps

module tbRvCore;
    import rvCorePkg::*;

    localparam int SEED       = 80620;
    localparam int PROG_LEN   = 200;
    localparam int MEM_WORDS  = 256;
    localparam int RST_CYCLES = 8;
    localparam int LOOP_SEEN  = 4;              // Self-loop fetches before the final checks
    localparam int WATCHDOG   = PROG_LEN * 4 + 200;

    logic            iCLK;
    logic            iRST;
    logic [XLEN-1:0] instr;
    logic [XLEN-1:0] pc;
    retireT          retire;
    logic [XLEN-1:0] retiredCount;

    logic [XLEN-1:0] imem [0:MEM_WORDS-1];
    retireT          expItem;
    int              errors   = 0;
    int              loopSeen = 0;
    logic            rstSeen  = 1'b1;           // Reset was high at the previous falling edge

    rvCore dut0 (
        .iCLK         (iCLK),
        .iRST         (iRST),
        .instr        (instr),
        .pc           (pc),
        .retire       (retire),
        .retiredCount (retiredCount)
    );

    tbRvModel #(.PROG_LEN(PROG_LEN)) model0 ();

    initial begin
        iCLK = 1'b0;
        forever #2 iCLK = ~iCLK;
    end

    // Synchronous instruction memory
    always @(posedge iCLK) begin
        instr <= imem[8'((pc - RESET_PC) >> 2)];
    end

    task automatic valueError(input string msg);
        errors++;
        $display("MISMATCH at %0t ns: %s", $time, msg);
    endtask

    task automatic endRun();
        $display("Checks done, errors: %0d", errors);
        if (errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    endtask

    // ********************
    // Checks on the falling edge

    always @(negedge iCLK) begin
        if (iRST || rstSeen) begin
            assert (!retire.valid && retiredCount == '0 && pc == RESET_PC)
                else valueError($sformatf("reset state valid=%b count=%0d pc=%h",
                                          retire.valid, retiredCount, pc));
        end
        if (!iRST && retire.valid) begin
            assert (retire.rd != '0)
                else valueError("write to x0 retired");
            assert (model0.expQ.size() > 0) else begin
                errors++;
                $display("Retire of x%0d at %0t ns with no write left in the model",
                         retire.rd, $time);
            end
            if (model0.expQ.size() > 0) begin
                expItem = model0.expQ.pop_front();
                assert (retire.rd == expItem.rd && retire.data == expItem.data)
                    else valueError($sformatf("retire x%0d=%h, expected x%0d=%h",
                                              retire.rd, retire.data, expItem.rd,
                                              expItem.data));
            end
        end
        if (!iRST && pc == model0.loopPc)
            loopSeen++;
        rstSeen = iRST;
    end

    // ********************
    // Stimulus

    initial begin
        iRST  = 1'b1;
        instr = NOP_INSTR;
        void'($urandom(SEED));
        model0.buildProgram();
        model0.runModel();
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = {20'(i), 5'd7, LUI};      // lui x7 with the word index
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            imem[i] = model0.prog[i];
        end
        repeat (RST_CYCLES) @(posedge iCLK);
        iRST <= 1'b0;
        while (loopSeen < LOOP_SEEN) @(negedge iCLK);
        @(negedge iCLK);
        assert (model0.expQ.size() == 0) else begin
            errors++;
            $display("%0d expected register writes never retired", model0.expQ.size());
        end
        assert (retiredCount >= model0.expCount)
            else valueError($sformatf("retiredCount %0d, expected at least %0d",
                                      retiredCount, model0.expCount));
        endRun();
    end

    // Watchdog
    initial begin
        repeat (WATCHDOG) @(posedge iCLK);
        errors++;
        $display("Timeout after %0d cycles, the program never reached its self-loop", WATCHDOG);
        endRun();
    end

endmodule

// ==== testbench/tbRvModel.sv ====
`timescale 1ns/1ps

module tbRvModel #(
    parameter int PROG_LEN = 200
);
    import rvCorePkg::*;

    logic [XLEN-1:0] prog [0:PROG_LEN-1];
    bit              isTarget [0:PROG_LEN-1];   // Landing slots of forward jumps
    retireT          expQ [$];                  // Expected register writes, in order
    int unsigned     expCount;                  // Instructions before the self-loop
    logic [XLEN-1:0] loopPc;

    function automatic logic [4:0] pickReg();
        return 5'($urandom_range(0, 5));        // Small set, so dependencies are common
    endfunction

    // ********************
    // Instruction encoders

    function automatic logic [31:0] encR(logic alt, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3, logic [4:0] rd);
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, OP};
    endfunction

    function automatic logic [31:0] encI(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                         logic [4:0] rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encU(logic [19:0] imm, logic [4:0] rd, logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] encB(logic [12:0] off, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], BRANCH};
    endfunction

    function automatic logic [31:0] encJ(logic [20:0] off, logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, JAL};
    endfunction

    // ********************
    // Program generator

    task automatic buildProgram();
        int              i;
        int              tgt;
        logic [2:0]      f3;
        logic [11:0]     imm;
        logic [XLEN-1:0] addr;
        for (int k = 0; k < PROG_LEN; k++) begin
            isTarget[k] = 1'b0;
        end
        i = 0;
        while (i < PROG_LEN - 1) begin
            f3  = 3'($urandom_range(0, 7));
            tgt = i + $urandom_range(1, 4);
            if (tgt > PROG_LEN - 1)
                tgt = PROG_LEN - 1;
            case ($urandom_range(0, 9))
                0, 1, 2: prog[i] = encR((f3 == 3'd0 || f3 == 3'd5) && $urandom_range(0, 1) == 1,
                                        pickReg(), pickReg(), f3, pickReg());
                3, 4: begin
                    imm = 12'($urandom);
                    if (f3 == 3'd1)
                        imm[11:5] = 7'b0;                   // slli
                    if (f3 == 3'd5)
                        imm[11:5] = {1'b0, imm[10], 5'b0};  // srli or srai
                    prog[i] = encI(imm, pickReg(), f3, pickReg(), OP_IMM);
                end
                5: prog[i] = encU(20'($urandom), pickReg(), LUI);
                6: prog[i] = encU(20'($urandom), pickReg(), AUIPC);
                7: begin
                    if (f3[2:1] == 2'b01)
                        f3[1] = 1'b0;                       // No branch for funct3 2 and 3
                    prog[i] = encB(13'((tgt - i) * 4), pickReg(), pickReg(), f3);
                    isTarget[tgt] = 1'b1;
                end
                8: begin
                    prog[i] = encJ(21'((tgt - i) * 4), pickReg());
                    isTarget[tgt] = 1'b1;
                end
                default: begin
                    // LUI/ADDI/JALR triple, nothing may jump into its middle
                    if (i + 3 < PROG_LEN && !isTarget[i+1] && !isTarget[i+2]) begin
                        tgt = i + 2 + $urandom_range(1, 3);
                        if (tgt > PROG_LEN - 1)
                            tgt = PROG_LEN - 1;
                        addr      = RESET_PC + XLEN'(tgt * 4);
                        prog[i]   = encU(20'((addr + 32'h800) >> 12), 5'd6, LUI);
                        prog[i+1] = encI(addr[11:0], 5'd6, 3'd0, 5'd6, OP_IMM);
                        prog[i+2] = encI(12'd1, 5'd6, 3'd0, pickReg(), JALR);  // Odd offset
                        isTarget[tgt] = 1'b1;
                        i += 2;
                    end else begin
                        prog[i] = encR(1'b0, pickReg(), pickReg(), 3'd0, pickReg());
                    end
                end
            endcase
            i++;
        end
        prog[PROG_LEN-1] = encJ(21'd0, 5'd0);   // Self-loop
        loopPc = RESET_PC + XLEN'((PROG_LEN - 1) * 4);
    endtask

    // ********************
    // Reference instruction-set model

    function automatic logic [31:0] aluRef(logic [2:0] f3, logic alt,
                                           logic [31:0] a, logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: begin
                if (alt)
                    return $signed(a) >>> b[4:0];
                else
                    return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic bit branchTaken(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            3'd7: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    task automatic runModel();
        logic [XLEN-1:0] x [0:31];
        logic [XLEN-1:0] pcM;
        logic [XLEN-1:0] ins;
        logic [XLEN-1:0] immI;
        logic [XLEN-1:0] res;
        logic [XLEN-1:0] nextPc;
        logic            wr;
        retireT          item;
        for (int k = 0; k < 32; k++) begin
            x[k] = '0;
        end
        pcM      = RESET_PC;
        expCount = 0;
        while (pcM != loopPc) begin
            ins    = prog[(pcM - RESET_PC) >> 2];
            immI   = {{20{ins[31]}}, ins[31:20]};
            nextPc = pcM + 32'd4;
            res    = pcM + 32'd4;           // Link value
            wr     = 1'b1;
            case (ins[6:0])
                OP:     res = aluRef(ins[14:12], ins[30], x[ins[19:15]], x[ins[24:20]]);
                OP_IMM: res = aluRef(ins[14:12], ins[30] && ins[14:12] == 3'd5,
                                     x[ins[19:15]], immI);
                LUI:    res = {ins[31:12], 12'b0};
                AUIPC:  res = pcM + {ins[31:12], 12'b0};
                JAL:    nextPc = pcM + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
                JALR:   nextPc = (x[ins[19:15]] + immI) & ~32'd1;
                default: begin
                    wr = 1'b0;
                    if (branchTaken(ins[14:12], x[ins[19:15]], x[ins[24:20]]))
                        nextPc = pcM + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                end
            endcase
            if (wr && ins[11:7] != 5'd0) begin
                x[ins[11:7]] = res;
                item.valid   = 1'b1;
                item.rd      = ins[11:7];
                item.data    = res;
                expQ.push_back(item);
            end
            expCount++;
            pcM = nextPc;
        end
    endtask

endmodule

// ==== vlog.f ====
design/rvCorePkg.sv
design/rvRegFile.sv
design/rvFetch.sv
design/rvDecode.sv
design/rvExecute.sv
design/rvResult.sv
design/rvCore.sv
testbench/tbRvModel.sv
testbench/tbRvCore.sv
